// File: Makefile
VERILATOR ?= verilator
TOP := tb_l1d_pipeline
FILELIST := tb.f
OBJ_DIR := obj_dir
LOG := sim.log
VFLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing --assert

.PHONY: all build run lint clean

all: build run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run:
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: src/l1d_data_sram.sv
// Line data storage with one registered read port and one write port
`timescale 1ns/1ps

module l1d_data_sram(
    input                               clk,

    input                               read_en,
    input l1d_pkg::l1d_way_idx_t        read_way,
    input l1d_pkg::l1d_set_idx_t        read_set,

    input                               write_en,
    input l1d_pkg::l1d_way_idx_t        write_way,
    input l1d_pkg::l1d_set_idx_t        write_set,
    input l1d_pkg::cache_line_data_t    write_data,

    output l1d_pkg::cache_line_data_t   read_data);

    l1d_pkg::cache_line_data_t mem[l1d_pkg::WAYS * l1d_pkg::SETS];
    logic [$clog2(l1d_pkg::WAYS * l1d_pkg::SETS) - 1:0] read_addr;
    logic [$clog2(l1d_pkg::WAYS * l1d_pkg::SETS) - 1:0] write_addr;

    // Way selects the bank, set the entry inside it
    assign read_addr = {read_way, read_set};
    assign write_addr = {write_way, write_set};

    always_ff @(posedge clk)
    begin
        if (write_en)
            mem[write_addr] <= write_data;

        // Colliding write is bypassed to the read port
        if (read_en)
        begin
            if (write_en && write_addr == read_addr)
                read_data <= write_data;
            else
                read_data <= mem[read_addr];
        end
    end

endmodule

// File: src/l1d_data_stage.sv
// Data stage hit check, miss, near-miss and fault decisions, sync load tracking and results
`timescale 1ns/1ps

module l1d_data_stage(
    input                                   clk,
    input                                   reset,

    // From tag stage
    input                                   t_valid,
    input l1d_pkg::thread_idx_t             t_thread,
    input l1d_pkg::scalar_t                 t_addr,
    input l1d_pkg::mem_access_t             t_type,
    input                                   t_load,
    input l1d_pkg::scalar_t                 t_store_value,
    input [l1d_pkg::WAYS - 1:0]             t_way_valid,
    input l1d_pkg::l1d_tag_t                t_way_tag[l1d_pkg::WAYS],

    // L2 fill
    input                                   fill_en,
    input l1d_pkg::l1d_way_idx_t            fill_way,
    input l1d_pkg::l1d_set_idx_t            fill_set,
    input l1d_pkg::l1d_tag_t                fill_tag,
    input l1d_pkg::cache_line_data_t        fill_data,

    // Results
    output logic                            resp_valid,
    output l1d_pkg::cache_line_data_t       load_data,
    output logic                            cache_miss,
    output l1d_pkg::line_index_t            miss_addr,
    output l1d_pkg::thread_idx_t            miss_thread,
    output logic                            miss_sync,
    output logic                            suspend_thread,
    output logic                            rollback,
    output logic                            fault,
    output logic                            fault_is_store,
    output logic                            store_en,
    output l1d_pkg::line_byte_mask_t        store_mask,
    output l1d_pkg::line_index_t            store_addr,
    output l1d_pkg::cache_line_data_t       store_data,
    output l1d_pkg::thread_idx_t            store_thread,
    output logic [l1d_pkg::THREADS - 1:0]   sync_load_pending);

    l1d_pkg::l1d_tag_t req_tag;
    l1d_pkg::l1d_set_idx_t req_set;
    logic [l1d_pkg::WAYS - 1:0] way_hit_oh;
    l1d_pkg::l1d_way_idx_t way_hit_idx;
    logic is_sync;
    logic cache_hit;
    logic unaligned;
    logic load_en;
    logic aligned_load;
    logic near_miss;
    logic miss_now;
    l1d_pkg::line_byte_mask_t align_mask;
    l1d_pkg::cache_line_data_t align_data;

    assign req_tag = t_addr[31 -: $bits(l1d_pkg::l1d_tag_t)];
    assign req_set = t_addr[l1d_pkg::OFFSET_WIDTH +: $bits(l1d_pkg::l1d_set_idx_t)];
    assign is_sync = t_type == l1d_pkg::MEM_SYNC;

    genvar way;
    generate
        for (way = 0; way < l1d_pkg::WAYS; way++)
        begin : hit_gen
            assign way_hit_oh[way] = t_way_valid[way] && t_way_tag[way] == req_tag;
        end
    endgenerate

    always_comb
    begin
        way_hit_idx = '0;
        for (int w = 0; w < l1d_pkg::WAYS; w++)
        begin
            if (way_hit_oh[w])
                way_hit_idx = way_hit_idx | l1d_pkg::l1d_way_idx_t'(w);
        end
    end

    // First sync load always goes to L2 to register the address
    assign cache_hit = |way_hit_oh && (!is_sync || sync_load_pending[t_thread]);

    l1d_store_align store_align0(
        .addr(t_addr),
        .access(t_type),
        .store_value(t_store_value),
        .store_mask(align_mask),
        .store_data(align_data),
        .unaligned(unaligned));

    assign load_en = t_valid && t_load;
    assign aligned_load = load_en && !unaligned;

    l1d_data_sram data_sram0(
        .clk(clk),
        .read_en(aligned_load && cache_hit),
        .read_way(way_hit_idx),
        .read_set(req_set),
        .write_en(fill_en),
        .write_way(fill_way),
        .write_set(fill_set),
        .write_data(fill_data),
        .read_data(load_data));

    // Line arrives while this miss is being decided, so a suspend would never wake.
    // Retry via rollback instead
    assign near_miss = aligned_load
        && !cache_hit
        && !is_sync
        && fill_en
        && fill_set == req_set
        && fill_tag == req_tag;

    assign miss_now = aligned_load && !cache_hit && !near_miss;

    // Pending bit marks that the first half of a sync load pair was seen
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            sync_load_pending <= '0;
        else if (aligned_load && is_sync)
            sync_load_pending[t_thread] <= !sync_load_pending[t_thread];
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            resp_valid <= 1'b0;
            cache_miss <= 1'b0;
            suspend_thread <= 1'b0;
            rollback <= 1'b0;
            fault <= 1'b0;
            store_en <= 1'b0;
        end
        else
        begin
            resp_valid <= t_valid;
            cache_miss <= miss_now;
            suspend_thread <= miss_now;
            rollback <= near_miss;
            fault <= t_valid && unaligned;
            store_en <= t_valid && !t_load && !unaligned;
        end
    end

    always_ff @(posedge clk)
    begin
        miss_addr <= t_addr[31:l1d_pkg::OFFSET_WIDTH];
        miss_thread <= t_thread;
        miss_sync <= is_sync;
        fault_is_store <= !t_load;
        store_mask <= align_mask;
        store_addr <= t_addr[31:l1d_pkg::OFFSET_WIDTH];
        store_data <= align_data;
        store_thread <= t_thread;
    end

    // Fills must keep a line in a single way
    assert property (@(posedge clk) disable iff (reset) load_en |-> $onehot0(way_hit_oh));

endmodule

// File: src/l1d_pipeline.sv
// L1 data cache pipeline top joining the tag stage and the data stage
`timescale 1ns/1ps

module l1d_pipeline(
    input                                   clk,
    input                                   reset,

    // Request
    input                                   req_valid,
    input l1d_pkg::thread_idx_t             req_thread,
    input l1d_pkg::scalar_t                 req_addr,
    input l1d_pkg::mem_access_t             req_type,
    input                                   req_load,
    input l1d_pkg::scalar_t                 req_store_value,

    // Fill from L2
    input                                   fill_en,
    input l1d_pkg::l1d_way_idx_t            fill_way,
    input l1d_pkg::l1d_set_idx_t            fill_set,
    input l1d_pkg::l1d_tag_t                fill_tag,
    input l1d_pkg::cache_line_data_t        fill_data,

    // Results
    output logic                            resp_valid,
    output l1d_pkg::cache_line_data_t       load_data,
    output logic                            cache_miss,
    output l1d_pkg::line_index_t            miss_addr,
    output l1d_pkg::thread_idx_t            miss_thread,
    output logic                            miss_sync,
    output logic                            suspend_thread,
    output logic                            rollback,
    output logic                            fault,
    output logic                            fault_is_store,
    output logic                            store_en,
    output l1d_pkg::line_byte_mask_t        store_mask,
    output l1d_pkg::line_index_t            store_addr,
    output l1d_pkg::cache_line_data_t       store_data,
    output l1d_pkg::thread_idx_t            store_thread,
    output logic [l1d_pkg::THREADS - 1:0]   sync_load_pending);

    logic t_valid;
    l1d_pkg::thread_idx_t t_thread;
    l1d_pkg::scalar_t t_addr;
    l1d_pkg::mem_access_t t_type;
    logic t_load;
    l1d_pkg::scalar_t t_store_value;
    logic [l1d_pkg::WAYS - 1:0] t_way_valid;
    l1d_pkg::l1d_tag_t t_way_tag[l1d_pkg::WAYS];

    l1d_tag_stage tag_stage0(
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req_thread(req_thread),
        .req_addr(req_addr),
        .req_type(req_type),
        .req_load(req_load),
        .req_store_value(req_store_value),
        .fill_en(fill_en),
        .fill_way(fill_way),
        .fill_set(fill_set),
        .fill_tag(fill_tag),
        .t_valid(t_valid),
        .t_thread(t_thread),
        .t_addr(t_addr),
        .t_type(t_type),
        .t_load(t_load),
        .t_store_value(t_store_value),
        .t_way_valid(t_way_valid),
        .t_way_tag(t_way_tag));

    l1d_data_stage data_stage0(
        .clk(clk),
        .reset(reset),
        .t_valid(t_valid),
        .t_thread(t_thread),
        .t_addr(t_addr),
        .t_type(t_type),
        .t_load(t_load),
        .t_store_value(t_store_value),
        .t_way_valid(t_way_valid),
        .t_way_tag(t_way_tag),
        .fill_en(fill_en),
        .fill_way(fill_way),
        .fill_set(fill_set),
        .fill_tag(fill_tag),
        .fill_data(fill_data),
        .resp_valid(resp_valid),
        .load_data(load_data),
        .cache_miss(cache_miss),
        .miss_addr(miss_addr),
        .miss_thread(miss_thread),
        .miss_sync(miss_sync),
        .suspend_thread(suspend_thread),
        .rollback(rollback),
        .fault(fault),
        .fault_is_store(fault_is_store),
        .store_en(store_en),
        .store_mask(store_mask),
        .store_addr(store_addr),
        .store_data(store_data),
        .store_thread(store_thread),
        .sync_load_pending(sync_load_pending));

endmodule

// File: src/l1d_pkg.sv
// L1 data cache geometry constants, vector typedefs and the memory access type enum
package l1d_pkg;

    // Hardware threads sharing the cache
    localparam int THREADS = 4;

    // Cache geometry
    localparam int WAYS = 4;
    localparam int SETS = 64;
    localparam int LINE_BYTES = 64;
    localparam int LINE_WORDS = LINE_BYTES / 4;
    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES);

    // Address or data word
    typedef logic [31:0] scalar_t;

    // Address split is tag | set | offset
    typedef logic [32 - OFFSET_WIDTH - $clog2(SETS) - 1:0] l1d_tag_t;
    typedef logic [$clog2(SETS) - 1:0] l1d_set_idx_t;
    typedef logic [$clog2(WAYS) - 1:0] l1d_way_idx_t;

    typedef logic [$clog2(THREADS) - 1:0] thread_idx_t;

    // Line address without the byte offset
    typedef logic [32 - OFFSET_WIDTH - 1:0] line_index_t;

    // One full line and its byte enables
    typedef logic [LINE_BYTES * 8 - 1:0] cache_line_data_t;
    typedef logic [LINE_BYTES - 1:0] line_byte_mask_t;

    // Access width of a scalar memory operation
    typedef enum logic [1:0]
    {
        MEM_B,
        MEM_S,
        MEM_L,
        MEM_SYNC
    } mem_access_t;

endpackage

// File: src/l1d_store_align.sv
// Store byte-enable mask, byte-swapped store data and unaligned access detection
`timescale 1ns/1ps

module l1d_store_align(
    input l1d_pkg::scalar_t             addr,
    input l1d_pkg::mem_access_t         access,
    input l1d_pkg::scalar_t             store_value,
    output l1d_pkg::line_byte_mask_t    store_mask,
    output l1d_pkg::cache_line_data_t   store_data,
    output logic                        unaligned);

    logic [$clog2(l1d_pkg::LINE_WORDS) - 1:0] word_idx;
    logic [l1d_pkg::LINE_WORDS - 1:0] word_oh;
    logic [3:0] byte_mask;

    // Word within the line
    assign word_idx = addr[l1d_pkg::OFFSET_WIDTH - 1:2];

    always_comb
    begin
        word_oh = '0;
        word_oh[word_idx] = 1'b1;
    end

    // Bit 3 is address byte 0 of the word (big-endian lanes)
    always_comb
    begin
        case (access)
            l1d_pkg::MEM_B:
                byte_mask = 4'b1000 >> addr[1:0];

            l1d_pkg::MEM_S:
            begin
                if (addr[1])
                    byte_mask = 4'b0011;
                else
                    byte_mask = 4'b1100;
            end

            default:
                byte_mask = 4'b1111;
        endcase
    end

    // Word 0 sits in the top 32 bits of the line, so walk bytes from the top
    genvar byte_idx;
    generate
        for (byte_idx = 0; byte_idx < l1d_pkg::LINE_BYTES; byte_idx++)
        begin : mask_gen
            assign store_mask[byte_idx] =
                word_oh[(l1d_pkg::LINE_BYTES - 1 - byte_idx) / 4] & byte_mask[byte_idx % 4];
        end
    endgenerate

    // Swap bytes and replicate, the mask picks the lanes that get written
    always_comb
    begin
        case (access)
            l1d_pkg::MEM_B:
                store_data = {l1d_pkg::LINE_BYTES{store_value[7:0]}};

            l1d_pkg::MEM_S:
                store_data = {l1d_pkg::LINE_WORDS * 2{store_value[7:0], store_value[15:8]}};

            default:
            begin
                store_data = {l1d_pkg::LINE_WORDS{store_value[7:0], store_value[15:8],
                    store_value[23:16], store_value[31:24]}};
            end
        endcase
    end

    always_comb
    begin
        case (access)
            l1d_pkg::MEM_S:
                unaligned = addr[0];
            l1d_pkg::MEM_L, l1d_pkg::MEM_SYNC:
                unaligned = |addr[1:0];
            default:
                unaligned = 1'b0;
        endcase
    end

endmodule

// File: src/l1d_tag_stage.sv
// Tag stage: per-way tag and valid arrays, fill update and the registered request
`timescale 1ns/1ps

module l1d_tag_stage(
    input                               clk,
    input                               reset,

    // Request
    input                               req_valid,
    input l1d_pkg::thread_idx_t         req_thread,
    input l1d_pkg::scalar_t             req_addr,
    input l1d_pkg::mem_access_t         req_type,
    input                               req_load,
    input l1d_pkg::scalar_t             req_store_value,

    // Tag update from L2 fill
    input                               fill_en,
    input l1d_pkg::l1d_way_idx_t        fill_way,
    input l1d_pkg::l1d_set_idx_t        fill_set,
    input l1d_pkg::l1d_tag_t            fill_tag,

    // To data stage
    output logic                        t_valid,
    output l1d_pkg::thread_idx_t        t_thread,
    output l1d_pkg::scalar_t            t_addr,
    output l1d_pkg::mem_access_t        t_type,
    output logic                        t_load,
    output l1d_pkg::scalar_t            t_store_value,
    output logic [l1d_pkg::WAYS - 1:0]  t_way_valid,
    output l1d_pkg::l1d_tag_t           t_way_tag[l1d_pkg::WAYS]);

    l1d_pkg::l1d_set_idx_t req_set;
    logic [l1d_pkg::WAYS - 1:0] dup_tag;

    assign req_set = req_addr[l1d_pkg::OFFSET_WIDTH +: $bits(l1d_pkg::l1d_set_idx_t)];

    genvar way;
    generate
        for (way = 0; way < l1d_pkg::WAYS; way++)
        begin : way_gen
            l1d_pkg::l1d_tag_t tag_mem[l1d_pkg::SETS];
            logic [l1d_pkg::SETS - 1:0] valid_bits;
            logic fill_this_way;
            logic fill_hits_read;

            assign fill_this_way = fill_en && fill_way == l1d_pkg::l1d_way_idx_t'(way);
            assign fill_hits_read = fill_this_way && fill_set == req_set;

            // Same tag already living in another way of the fill set
            assign dup_tag[way] = !fill_this_way
                && valid_bits[fill_set]
                && tag_mem[fill_set] == fill_tag;

            always_ff @(posedge clk)
            begin
                if (fill_this_way)
                    tag_mem[fill_set] <= fill_tag;

                // Fill at the read edge wins over the stored tag
                if (fill_hits_read)
                    t_way_tag[way] <= fill_tag;
                else
                    t_way_tag[way] <= tag_mem[req_set];

                t_way_valid[way] <= valid_bits[req_set] || fill_hits_read;
            end

            always_ff @(posedge clk, posedge reset)
            begin
                if (reset)
                    valid_bits <= '0;
                else if (fill_this_way)
                    valid_bits[fill_set] <= 1'b1;
            end
        end
    endgenerate

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            t_valid <= 1'b0;
        else
            t_valid <= req_valid;
    end

    // Request payload follows the tag read
    always_ff @(posedge clk)
    begin
        t_thread <= req_thread;
        t_addr <= req_addr;
        t_type <= req_type;
        t_load <= req_load;
        t_store_value <= req_store_value;
    end

    // L2 must not load a line that is already resident in another way
    assert property (@(posedge clk) disable iff (reset) fill_en |-> dup_tag == '0);

endmodule

// File: tb.f
src/l1d_pkg.sv
src/l1d_store_align.sv
src/l1d_data_sram.sv
src/l1d_tag_stage.sv
src/l1d_data_stage.sv
src/l1d_pipeline.sv
testbench/tb_clock_gen.sv
testbench/tb_l1d_pipeline.sv

// File: testbench/l1d_stim.txt
# op thread_or_way addr type value hit miss rollback fault, all hex, one line per cycle
# op 0 idle, 1 fill (value is the seed word), 2 load, 3 sync load, 4 store; type 0 B 1 S 2 L 3 SYNC
1 0 12345040 0 10000000 0 0 0 0
1 1 0abcd0c0 0 20000000 0 0 0 0
2 0 12345044 2 00000000 1 0 0 0
2 1 0abcd0c8 2 00000000 1 0 0 0
2 2 55555048 2 00000000 0 1 0 0
0 0 00000000 0 00000000 0 0 0 0
4 1 12345043 0 000000a5 0 0 0 0
4 2 1234504e 1 0000beef 0 0 0 0
4 3 1234507c 2 01020304 0 0 0 0
4 0 12345061 0 0000007f 0 0 0 0
2 0 12345045 1 00000000 0 0 0 1
4 1 1234504a 2 deadbeef 0 0 0 1
3 1 12345042 3 00000000 0 0 0 1
3 1 12345040 3 00000000 0 1 0 0
3 2 0abcd0c0 3 00000000 0 1 0 0
3 1 12345040 3 00000000 1 0 0 0
3 2 0abcd0c0 3 00000000 1 0 0 0
2 3 77777208 2 00000000 0 0 1 0
1 2 77777200 0 30000000 0 0 0 0
2 3 77777210 2 00000000 1 0 0 0
2 0 12345046 1 00000000 1 0 0 0
2 2 0abcd0d1 0 00000000 1 0 0 0
0 0 00000000 0 00000000 0 0 0 0

// File: testbench/tb_clock_gen.sv
// Testbench clock and reset generator: 10 ns clock period, reset held high for two cycles
`timescale 1ns/1ps

module tb_clock_gen(
    output logic clk,
    output logic reset);

    localparam time HALF_PERIOD = 5ns;

    initial
    begin
        clk = 1'b0;
        forever
            #HALF_PERIOD clk = ~clk;
    end

    // Release on a falling edge so the first active edge sees a clean reset
    initial
    begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: testbench/tb_l1d_pipeline.sv
// Testbench for the L1 data cache pipeline: stimulus file reader, DUT drive, reference checks
`timescale 1ns/1ps

module tb_l1d_pipeline;

    typedef logic [511:0] wide_t;

    logic clk;
    logic reset;

    logic req_valid;
    l1d_pkg::thread_idx_t req_thread;
    l1d_pkg::scalar_t req_addr;
    l1d_pkg::mem_access_t req_type;
    logic req_load;
    l1d_pkg::scalar_t req_store_value;
    logic fill_en;
    l1d_pkg::l1d_way_idx_t fill_way;
    l1d_pkg::l1d_set_idx_t fill_set;
    l1d_pkg::l1d_tag_t fill_tag;
    l1d_pkg::cache_line_data_t fill_data;

    logic resp_valid;
    l1d_pkg::cache_line_data_t load_data;
    logic cache_miss;
    l1d_pkg::line_index_t miss_addr;
    l1d_pkg::thread_idx_t miss_thread;
    logic miss_sync;
    logic suspend_thread;
    logic rollback;
    logic fault;
    logic fault_is_store;
    logic store_en;
    l1d_pkg::line_byte_mask_t store_mask;
    l1d_pkg::line_index_t store_addr;
    l1d_pkg::cache_line_data_t store_data;
    l1d_pkg::thread_idx_t store_thread;
    logic [l1d_pkg::THREADS - 1:0] sync_load_pending;

    // One entry per stimulus line
    logic [31:0] op_q[$];
    logic [31:0] thread_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] type_q[$];
    logic [31:0] value_q[$];
    logic [31:0] hit_q[$];
    logic [31:0] miss_q[$];
    logic [31:0] rollback_q[$];
    logic [31:0] fault_q[$];

    // Requests in flight, oldest first
    int exp_q[$];

    // Seed word of every line filled so far, by line address
    l1d_pkg::scalar_t seed_of[l1d_pkg::line_index_t];
    logic [l1d_pkg::THREADS - 1:0] pending_model;

    int errors;
    int checks;
    int cycle_count;
    int cycle_limit;
    int n;
    int step;
    bit file_ok;

    tb_clock_gen clock_gen0(
        .clk(clk),
        .reset(reset));

    l1d_pipeline dut0(
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req_thread(req_thread),
        .req_addr(req_addr),
        .req_type(req_type),
        .req_load(req_load),
        .req_store_value(req_store_value),
        .fill_en(fill_en),
        .fill_way(fill_way),
        .fill_set(fill_set),
        .fill_tag(fill_tag),
        .fill_data(fill_data),
        .resp_valid(resp_valid),
        .load_data(load_data),
        .cache_miss(cache_miss),
        .miss_addr(miss_addr),
        .miss_thread(miss_thread),
        .miss_sync(miss_sync),
        .suspend_thread(suspend_thread),
        .rollback(rollback),
        .fault(fault),
        .fault_is_store(fault_is_store),
        .store_en(store_en),
        .store_mask(store_mask),
        .store_addr(store_addr),
        .store_data(store_data),
        .store_thread(store_thread),
        .sync_load_pending(sync_load_pending));

    // Word i of a filled line is seed + i, word 0 in the top bits
    function automatic l1d_pkg::cache_line_data_t build_line(input l1d_pkg::scalar_t seed);
        l1d_pkg::cache_line_data_t line;
        line = '0;
        for (int i = 0; i < l1d_pkg::LINE_WORDS; i++)
            line[511 - 32 * i -: 32] = seed + l1d_pkg::scalar_t'(i);
        return line;
    endfunction

    // Address byte k sits at line bits 511-8k and gets byte (k mod size) of the value
    function automatic void expect_store(input l1d_pkg::scalar_t addr, input logic [1:0] kind,
        input l1d_pkg::scalar_t value, output l1d_pkg::line_byte_mask_t mask,
        output l1d_pkg::cache_line_data_t data);
        int size;
        int offset;
        int base;
        size = (kind == 2'd0) ? 1 : (kind == 2'd1) ? 2 : 4;
        offset = int'(addr[5:0]);
        base = offset - (offset % size);
        mask = '0;
        data = '0;
        for (int k = 0; k < l1d_pkg::LINE_BYTES; k++)
        begin
            data[511 - 8 * k -: 8] = value[8 * (k % size) +: 8];
            if (k >= base && k < base + size)
                mask[63 - k] = 1'b1;
        end
    endfunction

    task automatic check_value(input string name, input wide_t got, input wide_t exp,
        input int idx);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("CHECK FAILED step %0d: %s got 0x%0h expected 0x%0h", idx, name, got, exp);
        end
    endtask

    task automatic read_stimulus(output bit ok);
        int fd;
        int code;
        string text;
        logic [31:0] f[9];
        ok = 1'b0;
        fd = $fopen("testbench/l1d_stim.txt", "r");
        if (fd != 0)
        begin
            ok = 1'b1;
            while ($fgets(text, fd) != 0)
            begin
                // Comment lines describe the columns
                if (text.len() == 0 || text.getc(0) == 8'h23)
                    continue;
                code = $sscanf(text, "%h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                if (code == 9)
                begin
                    op_q.push_back(f[0]);
                    thread_q.push_back(f[1]);
                    addr_q.push_back(f[2]);
                    type_q.push_back(f[3]);
                    value_q.push_back(f[4]);
                    hit_q.push_back(f[5]);
                    miss_q.push_back(f[6]);
                    rollback_q.push_back(f[7]);
                    fault_q.push_back(f[8]);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_idle();
        req_valid = 1'b0;
        req_thread = '0;
        req_addr = '0;
        req_type = l1d_pkg::MEM_B;
        req_load = 1'b0;
        req_store_value = '0;
        fill_en = 1'b0;
        fill_way = '0;
        fill_set = '0;
        fill_tag = '0;
        fill_data = '0;
    endtask

    task automatic apply_step(input int idx);
        logic [31:0] op;
        l1d_pkg::scalar_t addr;
        op = op_q[idx];
        addr = addr_q[idx];
        drive_idle();
        if (op == 32'd1)
        begin
            fill_en = 1'b1;
            fill_way = l1d_pkg::l1d_way_idx_t'(thread_q[idx]);
            fill_set = addr[11:6];
            fill_tag = addr[31:12];
            fill_data = build_line(value_q[idx]);
            seed_of[addr[31:6]] = value_q[idx];
        end
        else if (op >= 32'd2 && op <= 32'd4)
        begin
            req_valid = 1'b1;
            req_thread = l1d_pkg::thread_idx_t'(thread_q[idx]);
            req_addr = addr;
            req_type = l1d_pkg::mem_access_t'(type_q[idx][1:0]);
            req_load = op != 32'd4;
            req_store_value = value_q[idx];
        end
    endtask

    task automatic check_reset_state();
        check_value("resp_valid", wide_t'(resp_valid), '0, -1);
        check_value("cache_miss", wide_t'(cache_miss), '0, -1);
        check_value("suspend_thread", wide_t'(suspend_thread), '0, -1);
        check_value("rollback", wide_t'(rollback), '0, -1);
        check_value("fault", wide_t'(fault), '0, -1);
        check_value("store_en", wide_t'(store_en), '0, -1);
        check_value("sync_load_pending", wide_t'(sync_load_pending), '0, -1);
    endtask

    task automatic check_result(input int idx);
        logic [31:0] op;
        l1d_pkg::scalar_t addr;
        logic is_req;
        logic is_store;
        logic exp_miss;
        logic exp_fault;
        logic exp_store;
        l1d_pkg::line_index_t line;
        l1d_pkg::line_byte_mask_t exp_mask;
        l1d_pkg::cache_line_data_t exp_data;
        op = op_q[idx];
        addr = addr_q[idx];
        line = addr[31:6];
        is_req = op >= 32'd2 && op <= 32'd4;
        is_store = op == 32'd4;
        exp_miss = miss_q[idx][0];
        exp_fault = fault_q[idx][0];
        exp_store = is_store && !exp_fault;

        check_value("resp_valid", wide_t'(resp_valid), wide_t'(is_req), idx);
        check_value("cache_miss", wide_t'(cache_miss), wide_t'(exp_miss), idx);
        check_value("suspend_thread", wide_t'(suspend_thread), wide_t'(exp_miss), idx);
        check_value("rollback", wide_t'(rollback), wide_t'(rollback_q[idx][0]), idx);
        check_value("fault", wide_t'(fault), wide_t'(exp_fault), idx);
        check_value("store_en", wide_t'(store_en), wide_t'(exp_store), idx);

        if (exp_miss)
        begin
            check_value("miss_addr", wide_t'(miss_addr), wide_t'(line), idx);
            check_value("miss_thread", wide_t'(miss_thread), wide_t'(thread_q[idx][1:0]), idx);
            check_value("miss_sync", wide_t'(miss_sync), wide_t'(op == 32'd3), idx);
        end

        if (exp_fault)
            check_value("fault_is_store", wide_t'(fault_is_store), wide_t'(is_store), idx);

        if (exp_store)
        begin
            expect_store(addr, type_q[idx][1:0], value_q[idx], exp_mask, exp_data);
            check_value("store_addr", wide_t'(store_addr), wide_t'(line), idx);
            check_value("store_thread", wide_t'(store_thread), wide_t'(thread_q[idx][1:0]), idx);
            check_value("store_mask", wide_t'(store_mask), wide_t'(exp_mask), idx);
            check_value("store_data", store_data, exp_data, idx);
        end

        if (is_req && !is_store && hit_q[idx][0])
        begin
            if (seed_of.exists(line))
                check_value("load_data", load_data, build_line(seed_of[line]), idx);
            else
            begin
                errors++;
                $display("Step %0d expects a hit on a line that was never filled", idx);
            end
        end

        // Aligned sync loads flip their thread's pending bit
        if (op == 32'd3 && !exp_fault)
            pending_model[thread_q[idx][1:0]] = ~pending_model[thread_q[idx][1:0]];
        check_value("sync_load_pending", wide_t'(sync_load_pending),
            wide_t'(pending_model), idx);
    endtask

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
        begin
            $display("Timeout after %0d cycles, the stimulus did not finish", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial
    begin
        errors = 0;
        checks = 0;
        cycle_count = 0;
        cycle_limit = 0;
        pending_model = '0;
        drive_idle();
        read_stimulus(file_ok);
        n = op_q.size();
        if (!file_ok || n == 0)
        begin
            $display("Stimulus file testbench/l1d_stim.txt is missing or empty");
            $display("SOME TESTS FAILED");
            $finish;
        end
        else
        begin
            cycle_limit = 2 * n + 20;
            @(negedge reset);
            @(negedge clk);
            check_reset_state();

            // Results come back two falling edges after their request was driven
            for (step = 0; step < n + 2; step++)
            begin
                if (exp_q.size() > 0 && exp_q[0] + 2 == step)
                    check_result(exp_q.pop_front());
                if (step < n)
                begin
                    apply_step(step);
                    exp_q.push_back(step);
                end
                else
                    drive_idle();
                @(negedge clk);
            end

            $display("Checks run: %0d, errors: %0d", checks, errors);
            if (errors == 0)
                $display("ALL TESTS PASSED");
            else
                $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule
